/* rtl/exu_pkg.sv */
// widths, opcodes, control encodings and instruction word views
package exu_pkg;

  localparam int xlen = 64;
  localparam int ilen = 32;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm32  = 7'b0011011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_reg32  = 7'b0111011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam int alu_ctr_w = 2;
  localparam logic [alu_ctr_w-1:0] alu_add  = 2'b00;
  localparam logic [alu_ctr_w-1:0] alu_sub  = 2'b01;
  localparam logic [alu_ctr_w-1:0] alu_slt  = 2'b10; // signed less-than as 1 or 0
  localparam logic [alu_ctr_w-1:0] alu_copy = 2'b11; // immediate through

  localparam int bsrc_w = 2;
  localparam logic [bsrc_w-1:0] bsrc_rs2  = 2'b00;
  localparam logic [bsrc_w-1:0] bsrc_imm  = 2'b01;
  localparam logic [bsrc_w-1:0] bsrc_four = 2'b10;

  localparam int branch_w = 3;
  localparam logic [branch_w-1:0] br_none = 3'b000;
  localparam logic [branch_w-1:0] br_jal  = 3'b001;
  localparam logic [branch_w-1:0] br_jalr = 3'b010;
  localparam logic [branch_w-1:0] br_eq   = 3'b100; // zero result
  localparam logic [branch_w-1:0] br_ne   = 3'b101;
  localparam logic [branch_w-1:0] br_lt   = 3'b110; // alu bit 0
  localparam logic [branch_w-1:0] br_ge   = 3'b111;

  // same as load funct3
  localparam int memop_w = 3;
  localparam logic [memop_w-1:0] mem_b  = 3'b000;
  localparam logic [memop_w-1:0] mem_h  = 3'b001;
  localparam logic [memop_w-1:0] mem_w  = 3'b010;
  localparam logic [memop_w-1:0] mem_d  = 3'b011;
  localparam logic [memop_w-1:0] mem_bu = 3'b100;
  localparam logic [memop_w-1:0] mem_hu = 3'b101;
  localparam logic [memop_w-1:0] mem_wu = 3'b110;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    // branch format with the immediate scattered
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
  } inst_u;

endpackage

/* rtl/exu_decode.sv */
// instruction decoder for control fields, immediate, illegal and ebreak flags
module exu_decode (
  input  exu_pkg::inst_u                     i_inst,
  output logic [exu_pkg::xlen-1:0]           o_imm,
  output logic                               o_asrc_pc,
  output logic [exu_pkg::bsrc_w-1:0]         o_bsrc,
  output logic [exu_pkg::alu_ctr_w-1:0]      o_alu_ctr,
  output logic                               o_word_cut,
  output logic [exu_pkg::branch_w-1:0]       o_branch,
  output logic [exu_pkg::memop_w-1:0]        o_memop,
  output logic                               o_mem_to_reg,
  output logic                               o_wb_en,
  output logic                               o_illegal,
  output logic                               o_ebreak
);

  logic [exu_pkg::xlen-1:0] imm_i, imm_u, imm_j, imm_b;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = i_inst.r.funct3;
  assign funct7 = i_inst.r.funct7;

  assign imm_i = {{52{i_inst.i.imm12[11]}}, i_inst.i.imm12};
  assign imm_u = {{32{funct7[6]}}, funct7, i_inst.r.rs2, i_inst.r.rs1, funct3, 12'b0};
  // j immediate gathered from the r view fields
  assign imm_j = {{44{funct7[6]}}, i_inst.r.rs1, funct3, i_inst.r.rs2[0],
                  funct7[5:0], i_inst.r.rs2[4:1], 1'b0};
  assign imm_b = {{52{i_inst.b.imm12}}, i_inst.b.imm11, i_inst.b.imm10_5,
                  i_inst.b.imm4_1, 1'b0};

  always_comb begin
    o_imm        = imm_i;
    o_asrc_pc    = 1'b0;
    o_bsrc       = exu_pkg::bsrc_imm;
    o_alu_ctr    = exu_pkg::alu_add;
    o_word_cut   = 1'b0;
    o_branch     = exu_pkg::br_none;
    o_memop      = funct3;
    o_mem_to_reg = 1'b0;
    o_wb_en      = 1'b1;
    o_illegal    = 1'b0;
    o_ebreak     = 1'b0;

    case (i_inst.r.opcode)
      exu_pkg::op_lui: begin
        o_imm     = imm_u;
        o_alu_ctr = exu_pkg::alu_copy;
      end
      exu_pkg::op_auipc: begin
        o_imm     = imm_u;
        o_asrc_pc = 1'b1;
      end
      exu_pkg::op_jal: begin
        o_imm     = imm_j;
        o_asrc_pc = 1'b1; // link = pc + 4
        o_bsrc    = exu_pkg::bsrc_four;
        o_branch  = exu_pkg::br_jal;
      end
      exu_pkg::op_jalr: begin
        o_asrc_pc = 1'b1;
        o_bsrc    = exu_pkg::bsrc_four;
        o_branch  = exu_pkg::br_jalr;
        o_illegal = (funct3 != 3'b000);
      end
      exu_pkg::op_branch: begin
        o_imm   = imm_b;
        o_bsrc  = exu_pkg::bsrc_rs2;
        o_wb_en = 1'b0;
        case (funct3)
          3'b000: begin
            o_alu_ctr = exu_pkg::alu_sub;
            o_branch  = exu_pkg::br_eq;
          end
          3'b001: begin
            o_alu_ctr = exu_pkg::alu_sub;
            o_branch  = exu_pkg::br_ne;
          end
          3'b100: begin
            o_alu_ctr = exu_pkg::alu_slt;
            o_branch  = exu_pkg::br_lt;
          end
          3'b101: begin
            o_alu_ctr = exu_pkg::alu_slt;
            o_branch  = exu_pkg::br_ge;
          end
          default: o_illegal = 1'b1; // no unsigned branches
        endcase
      end
      exu_pkg::op_load: begin
        o_mem_to_reg = 1'b1;
        o_illegal    = (funct3 == 3'b111);
      end
      exu_pkg::op_imm: begin
        if (funct3 == 3'b010) o_alu_ctr = exu_pkg::alu_slt;
        else if (funct3 != 3'b000) o_illegal = 1'b1;
      end
      exu_pkg::op_imm32: begin
        o_word_cut = 1'b1;
        o_illegal  = (funct3 != 3'b000); // addiw only
      end
      exu_pkg::op_reg, exu_pkg::op_reg32: begin
        o_bsrc     = exu_pkg::bsrc_rs2;
        o_word_cut = (i_inst.r.opcode == exu_pkg::op_reg32);
        if (funct7 == 7'b0000000 && funct3 == 3'b000) o_alu_ctr = exu_pkg::alu_add;
        else if (funct7 == 7'b0100000 && funct3 == 3'b000) o_alu_ctr = exu_pkg::alu_sub;
        else if (funct7 == 7'b0000000 && funct3 == 3'b010 && !o_word_cut)
          o_alu_ctr = exu_pkg::alu_slt;
        else o_illegal = 1'b1;
      end
      exu_pkg::op_system: begin
        o_wb_en = 1'b0;
        if (i_inst.i.imm12 == 12'd1 && i_inst.i.rs1 == 5'd0 && funct3 == 3'b000 &&
            i_inst.i.rd == 5'd0)
          o_ebreak = 1'b1;
        else
          o_illegal = 1'b1;
      end
      default: o_illegal = 1'b1;
    endcase

    if (o_illegal) begin
      o_wb_en  = 1'b0;
      o_branch = exu_pkg::br_none;
    end
  end

endmodule

/* rtl/exu_execute.sv */
// execute stage with operand select, word cut, alu, branch condition and next pc
module exu_execute (
  input  logic [exu_pkg::xlen-1:0]      i_pc,
  input  logic [exu_pkg::xlen-1:0]      i_rs1,
  input  logic [exu_pkg::xlen-1:0]      i_rs2,
  input  logic [exu_pkg::xlen-1:0]      i_imm,
  input  logic                          i_asrc_pc,
  input  logic [exu_pkg::bsrc_w-1:0]    i_bsrc,
  input  logic [exu_pkg::alu_ctr_w-1:0] i_alu_ctr,
  input  logic                          i_word_cut,
  input  logic [exu_pkg::branch_w-1:0]  i_branch,
  output logic [exu_pkg::xlen-1:0]      o_alu_result,
  output logic [exu_pkg::xlen-1:0]      o_next_pc
);

  logic [exu_pkg::xlen-1:0] src_a, src_b;
  logic [exu_pkg::xlen-1:0] op_a, op_b;
  logic [exu_pkg::xlen-1:0] sum, diff, alu_raw;
  logic [exu_pkg::xlen-1:0] pc_base, pc_off, target;
  logic lt, zero, taken;

  assign src_a = i_asrc_pc ? i_pc : i_rs1;

  always_comb begin
    case (i_bsrc)
      exu_pkg::bsrc_rs2:  src_b = i_rs2;
      exu_pkg::bsrc_four: src_b = exu_pkg::xlen'(4);
      default:            src_b = i_imm;
    endcase
  end

  // w ops see only the low word
  assign op_a = i_word_cut ? {32'b0, src_a[31:0]} : src_a;
  assign op_b = i_word_cut ? {32'b0, src_b[31:0]} : src_b;

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;
  assign lt   = $signed(op_a) < $signed(op_b); // true signed compare

  always_comb begin
    case (i_alu_ctr)
      exu_pkg::alu_add:  alu_raw = sum;
      exu_pkg::alu_sub:  alu_raw = diff;
      exu_pkg::alu_slt:  alu_raw = {63'b0, lt};
      default:           alu_raw = i_imm;
    endcase
  end

  assign o_alu_result = i_word_cut ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  assign zero = ~(|o_alu_result);

  always_comb begin
    case (i_branch)
      exu_pkg::br_jal, exu_pkg::br_jalr: taken = 1'b1;
      exu_pkg::br_eq:  taken = zero;
      exu_pkg::br_ne:  taken = ~zero;
      exu_pkg::br_lt:  taken = o_alu_result[0];
      exu_pkg::br_ge:  taken = ~o_alu_result[0];
      default:         taken = 1'b0;
    endcase
  end

  assign pc_base = (i_branch == exu_pkg::br_jalr) ? i_rs1 : i_pc;
  assign pc_off  = taken ? i_imm : exu_pkg::xlen'(4);
  assign target  = pc_base + pc_off;

  // jalr drops bit 0 of the target
  assign o_next_pc = (i_branch == exu_pkg::br_jalr) ? {target[63:1], 1'b0} : target;

endmodule

/* rtl/exu_result.sv */
// load extension, write-back select, output registers and req/ack control
module exu_result (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  logic                         i_req,
  input  logic [exu_pkg::xlen-1:0]     i_alu_result,
  input  logic [exu_pkg::xlen-1:0]     i_next_pc,
  input  logic [exu_pkg::xlen-1:0]     i_rdata,
  input  logic [exu_pkg::memop_w-1:0]  i_memop,
  input  logic                         i_mem_to_reg,
  input  logic                         i_wb_en,
  input  logic                         i_illegal,
  input  logic                         i_ebreak,
  output logic                         o_ack,
  output logic [exu_pkg::xlen-1:0]     o_alu_result,
  output logic [exu_pkg::xlen-1:0]     o_next_pc,
  output logic [exu_pkg::xlen-1:0]     o_wb_data,
  output logic                         o_wb_en,
  output logic                         o_illegal,
  output logic                         o_ebreak
);

  logic [exu_pkg::xlen-1:0] ld_ext, wb_data;
  logic capture;

  always_comb begin
    case (i_memop)
      exu_pkg::mem_b:  ld_ext = {{56{i_rdata[7]}}, i_rdata[7:0]};
      exu_pkg::mem_bu: ld_ext = {56'b0, i_rdata[7:0]};
      exu_pkg::mem_h:  ld_ext = {{48{i_rdata[15]}}, i_rdata[15:0]};
      exu_pkg::mem_hu: ld_ext = {48'b0, i_rdata[15:0]};
      exu_pkg::mem_w:  ld_ext = {{32{i_rdata[31]}}, i_rdata[31:0]};
      exu_pkg::mem_wu: ld_ext = {32'b0, i_rdata[31:0]};
      default:         ld_ext = i_rdata; // ld
    endcase
  end

  assign wb_data = i_mem_to_reg ? ld_ext : i_alu_result;
  assign capture = i_req & ~o_ack;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ack        <= 1'b0;
      o_alu_result <= '0;
      o_next_pc    <= '0;
      o_wb_data    <= '0;
      o_wb_en      <= 1'b0;
      o_illegal    <= 1'b0;
      o_ebreak     <= 1'b0;
    end else if (capture) begin
      o_ack        <= 1'b1;
      o_alu_result <= i_alu_result;
      o_next_pc    <= i_next_pc;
      o_wb_data    <= wb_data;
      o_wb_en      <= i_wb_en;
      o_illegal    <= i_illegal;
      o_ebreak     <= i_ebreak;
    end else if (!i_req && o_ack) begin
      o_ack <= 1'b0; // requester let go and results stay
    end
  end

endmodule

/* rtl/exu_top.sv */
// execute stage top connecting decode, execute and result
module exu_top (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_req,
  output logic                     o_ack,
  input  logic [exu_pkg::ilen-1:0] i_inst,
  input  logic [exu_pkg::xlen-1:0] i_pc,
  input  logic [exu_pkg::xlen-1:0] i_rs1,
  input  logic [exu_pkg::xlen-1:0] i_rs2,
  input  logic [exu_pkg::xlen-1:0] i_rdata,
  output logic [exu_pkg::xlen-1:0] o_alu_result,
  output logic [exu_pkg::xlen-1:0] o_next_pc,
  output logic [exu_pkg::xlen-1:0] o_wb_data,
  output logic                     o_wb_en,
  output logic                     o_illegal,
  output logic                     o_ebreak
);

  logic [exu_pkg::xlen-1:0]      imm, alu_result, next_pc;
  logic                          asrc_pc, word_cut, mem_to_reg;
  logic                          wb_en, illegal, ebreak;
  logic [exu_pkg::bsrc_w-1:0]    bsrc;
  logic [exu_pkg::alu_ctr_w-1:0] alu_ctr;
  logic [exu_pkg::branch_w-1:0]  branch;
  logic [exu_pkg::memop_w-1:0]   memop;

  exu_decode u_decode (
    .i_inst(i_inst), .o_imm(imm), .o_asrc_pc(asrc_pc), .o_bsrc(bsrc),
    .o_alu_ctr(alu_ctr), .o_word_cut(word_cut), .o_branch(branch), .o_memop(memop),
    .o_mem_to_reg(mem_to_reg), .o_wb_en(wb_en), .o_illegal(illegal), .o_ebreak(ebreak)
  );

  exu_execute u_execute (
    .i_pc(i_pc), .i_rs1(i_rs1), .i_rs2(i_rs2), .i_imm(imm), .i_asrc_pc(asrc_pc),
    .i_bsrc(bsrc), .i_alu_ctr(alu_ctr), .i_word_cut(word_cut), .i_branch(branch),
    .o_alu_result(alu_result), .o_next_pc(next_pc)
  );

  exu_result u_result (
    .i_clk(i_clk), .i_reset(i_reset), .i_req(i_req), .i_alu_result(alu_result),
    .i_next_pc(next_pc), .i_rdata(i_rdata), .i_memop(memop), .i_mem_to_reg(mem_to_reg),
    .i_wb_en(wb_en), .i_illegal(illegal), .i_ebreak(ebreak), .o_ack(o_ack),
    .o_alu_result(o_alu_result), .o_next_pc(o_next_pc), .o_wb_data(o_wb_data),
    .o_wb_en(o_wb_en), .o_illegal(o_illegal), .o_ebreak(o_ebreak)
  );

endmodule

/* tests/exu_tb.sv */
// execute stage testbench with lfsr stimulus, encoder, reference model and checks
module exu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic i_clk = 1'b0;
  logic i_reset, i_req, o_ack, o_wb_en, o_illegal, o_ebreak;
  logic [31:0] i_inst;
  logic [63:0] i_pc, i_rs1, i_rs2, i_rdata, o_alu_result, o_next_pc, o_wb_data;
  logic [63:0] cur_pc, cur_rs1, cur_rs2, cur_rdata, exp_alu, exp_pc, exp_wb;
  logic exp_wb_en, exp_ill, exp_ebr, chk_alu;
  logic hung = 1'b0;
  logic [15:0] lfsr = 16'd23394;
  int errors = 0, n_trans = 0, tests = 0, err_mark = 0, trans_mark = 0;
  int ack_limit = 8; // cycles allowed per handshake edge

  exu_top UUT (.*);

  always #20 i_clk = ~i_clk;

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16+x^14+x^13+x^11+1
      lfsr = {lfsr[14:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] encode(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [6:0] f7, input logic [63:0] imm);
    case (op)
      exu_pkg::op_lui, exu_pkg::op_auipc: return {imm[31:12], 5'd1, op};
      exu_pkg::op_jal: return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, op};
      exu_pkg::op_branch: return {imm[12], imm[10:5], 5'd3, 5'd2, f3, imm[4:1], imm[11], op};
      exu_pkg::op_reg, exu_pkg::op_reg32: return {f7, 5'd3, 5'd2, f3, 5'd1, op};
      exu_pkg::op_system: return {12'd1, 5'd0, 3'd0, 5'd0, op}; // ebreak
      default: return {imm[11:0], 5'd2, f3, 5'd1, op};
    endcase
  endfunction

  // expected results straight from the rv64i rules
  function automatic void predict(input logic [6:0] op, input logic [2:0] f3,
                                  input logic [6:0] f7, input logic [63:0] imm);
    logic [63:0] b;
    logic [31:0] w;
    logic tk;
    b = (op == exu_pkg::op_reg || op == exu_pkg::op_reg32) ? cur_rs2 : imm;
    exp_alu = '0;
    exp_pc = cur_pc + 64'd4;
    {exp_wb_en, exp_ill, exp_ebr, chk_alu} = 4'b1001;
    case (op)
      exu_pkg::op_lui: exp_alu = imm;
      exu_pkg::op_auipc: exp_alu = cur_pc + imm;
      exu_pkg::op_jal: begin
        exp_alu = cur_pc + 64'd4; // link
        exp_pc = cur_pc + imm;
      end
      exu_pkg::op_jalr: begin
        exp_alu = cur_pc + 64'd4;
        exp_pc = (cur_rs1 + imm) & ~64'd1;
      end
      exu_pkg::op_branch: begin
        case (f3)
          3'd0: tk = (cur_rs1 == cur_rs2);
          3'd1: tk = (cur_rs1 != cur_rs2);
          3'd4: tk = ($signed(cur_rs1) < $signed(cur_rs2));
          default: tk = ($signed(cur_rs1) >= $signed(cur_rs2));
        endcase
        if (tk) exp_pc = cur_pc + imm;
        {exp_wb_en, chk_alu} = 2'b00;
      end
      exu_pkg::op_load: exp_alu = cur_rs1 + imm;
      exu_pkg::op_imm32, exu_pkg::op_reg32: begin
        if (op == exu_pkg::op_reg32 && f7 == 7'h20) w = cur_rs1[31:0] - b[31:0];
        else w = cur_rs1[31:0] + b[31:0];
        exp_alu = {{32{w[31]}}, w};
      end
      exu_pkg::op_imm, exu_pkg::op_reg: begin
        if (f3 == 3'd2) exp_alu = ($signed(cur_rs1) < $signed(b)) ? 64'd1 : 64'd0;
        else if (op == exu_pkg::op_reg && f7 == 7'h20) exp_alu = cur_rs1 - b;
        else exp_alu = cur_rs1 + b;
      end
      exu_pkg::op_system: {exp_wb_en, exp_ebr, chk_alu} = 3'b010;
      default: {exp_wb_en, exp_ill, chk_alu} = 3'b010;
    endcase
    exp_wb = exp_alu;
    if (op == exu_pkg::op_load) begin
      case (f3)
        3'd0: exp_wb = {{56{cur_rdata[7]}}, cur_rdata[7:0]};
        3'd1: exp_wb = {{48{cur_rdata[15]}}, cur_rdata[15:0]};
        3'd2: exp_wb = {{32{cur_rdata[31]}}, cur_rdata[31:0]};
        3'd4: exp_wb = {56'd0, cur_rdata[7:0]};
        3'd5: exp_wb = {48'd0, cur_rdata[15:0]};
        3'd6: exp_wb = {32'd0, cur_rdata[31:0]};
        default: exp_wb = cur_rdata;
      endcase
    end
  endfunction

  task automatic flag_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic new_operands();
    cur_pc = rand_bits(62) << 2;
    cur_rs1 = rand_bits(64);
    cur_rs2 = (rand_bits(1) != 0) ? cur_rs1 : rand_bits(64); // equal now and then
    cur_rdata = rand_bits(64);
  endtask

  // one full four-phase transaction followed by a hold check and the compare
  task automatic run_word(input logic [31:0] inst, input logic [6:0] op,
                          input logic [2:0] f3, input logic [6:0] f7, input logic [63:0] imm);
    int n;
    logic [194:0] held;
    if (hung) return;
    predict(op, f3, f7, imm);
    {i_inst, i_pc, i_rs1, i_rs2, i_rdata} = {inst, cur_pc, cur_rs1, cur_rs2, cur_rdata};
    i_req = 1'b1;
    n = 0;
    do begin
      @(posedge i_clk);
      #2;
      n++;
    end while (!o_ack && n < ack_limit);
    if (!o_ack) begin
      $display("handshake timed out at %0t because o_ack never rose", $time);
      errors++;
      hung = 1'b1;
      return;
    end
    if (n != 1) flag_error($sformatf("o_ack rose after %0d cycles", n));
    i_req = 1'b0;
    n = 0;
    do begin
      @(posedge i_clk);
      #2;
      n++;
    end while (o_ack && n < ack_limit);
    if (o_ack) begin
      $display("handshake timed out at %0t because o_ack never fell", $time);
      errors++;
      hung = 1'b1;
      return;
    end
    if (n != 1) flag_error($sformatf("o_ack fell after %0d cycles", n));
    held = {o_alu_result, o_next_pc, o_wb_data, o_wb_en, o_illegal, o_ebreak};
    i_inst = 32'(rand_bits(32));
    {i_pc, i_rs1} = {rand_bits(64), rand_bits(64)};
    {i_rs2, i_rdata} = {rand_bits(64), rand_bits(64)};
    @(posedge i_clk);
    #2;
    if ({o_alu_result, o_next_pc, o_wb_data, o_wb_en, o_illegal, o_ebreak} !== held)
      flag_error($sformatf("outputs changed with i_req low, inst %h", inst));
    if (chk_alu && o_alu_result !== exp_alu)
      flag_error($sformatf("inst %h alu_result %h, expected %h", inst, o_alu_result, exp_alu));
    if (o_next_pc !== exp_pc)
      flag_error($sformatf("inst %h next_pc %h, expected %h", inst, o_next_pc, exp_pc));
    if (exp_wb_en && o_wb_data !== exp_wb)
      flag_error($sformatf("inst %h wb_data %h, expected %h", inst, o_wb_data, exp_wb));
    if ({o_wb_en, o_illegal, o_ebreak} !== {exp_wb_en, exp_ill, exp_ebr})
      flag_error($sformatf("inst %h flags %b, expected %b", inst,
                           {o_wb_en, o_illegal, o_ebreak}, {exp_wb_en, exp_ill, exp_ebr}));
    n_trans++;
  endtask

  task automatic exec(input logic [6:0] op, input logic [2:0] f3, input logic [6:0] f7,
                      input logic [63:0] imm);
    run_word(encode(op, f3, f7, imm), op, f3, f7, imm);
  endtask

  task automatic end_test(input string name);
    $display("test %s %0d transactions, %0d errors", name, n_trans - trans_mark,
             errors - err_mark);
    trans_mark = n_trans;
    err_mark = errors;
    tests++;
  endtask

  initial begin
    logic [63:0] imm;
    logic [31:0] w;
    logic [2:0] f3;
    {i_reset, i_req, i_inst, i_pc, i_rs1, i_rs2, i_rdata} = {1'b1, 1'b0, 288'd0};
    repeat (5) @(posedge i_clk);
    #2;
    if ({o_ack, o_wb_en, o_illegal, o_ebreak} !== 4'd0 || o_alu_result !== '0 ||
        o_next_pc !== '0 || o_wb_data !== '0)
      flag_error("outputs not cleared by reset");
    i_reset = 1'b0;
    end_test("reset");

    for (int k = 0; k < 28; k++) begin
      new_operands();
      imm = rand_bits(12);
      imm = {{52{imm[11]}}, imm[11:0]};
      case (k % 7)
        0: exec(exu_pkg::op_reg, 3'd0, 7'h00, imm);
        1: exec(exu_pkg::op_reg, 3'd0, 7'h20, imm);
        2: exec(exu_pkg::op_reg, 3'd2, 7'h00, imm);
        3: exec(exu_pkg::op_imm, 3'd0, 7'h00, imm);
        4: exec(exu_pkg::op_imm, 3'd2, 7'h00, imm);
        default: begin
          imm = rand_bits(20);
          imm = {{32{imm[19]}}, imm[19:0], 12'd0};
          exec((k % 7 == 5) ? exu_pkg::op_lui : exu_pkg::op_auipc, 3'd0, 7'h00, imm);
        end
      endcase
    end
    end_test("integer");

    for (int k = 0; k < 18; k++) begin
      new_operands();
      imm = rand_bits(12);
      imm = {{52{imm[11]}}, imm[11:0]};
      if (k % 3 == 2) exec(exu_pkg::op_imm32, 3'd0, 7'h00, imm);
      else exec(exu_pkg::op_reg32, 3'd0, (k % 3 == 1) ? 7'h20 : 7'h00, imm);
    end
    end_test("word");

    for (int k = 0; k < 30; k++) begin
      new_operands();
      imm = rand_bits(12);
      if (k % 6 < 4) begin
        imm = {{51{imm[11]}}, imm[11:0], 1'b0};
        f3 = (k % 6 < 2) ? 3'(k % 6) : 3'(k % 6 + 2); // beq bne blt bge
        exec(exu_pkg::op_branch, f3, 7'h00, imm);
      end else if (k % 6 == 4) begin
        imm = rand_bits(20);
        exec(exu_pkg::op_jal, 3'd0, 7'h00, {{43{imm[19]}}, imm[19:0], 1'b0});
      end else begin
        exec(exu_pkg::op_jalr, 3'd0, 7'h00, {{52{imm[11]}}, imm[11:0]});
      end
    end
    end_test("control");

    for (int k = 0; k < 21; k++) begin
      new_operands();
      imm = rand_bits(12);
      exec(exu_pkg::op_load, 3'(k % 7), 7'h00, {{52{imm[11]}}, imm[11:0]});
    end
    end_test("load");

    for (int k = 0; k < 10; k++) begin
      new_operands();
      w = 32'(rand_bits(32));
      w[1:0] = 2'b00; // never a 32-bit opcode
      if (k < 2) exec(exu_pkg::op_system, 3'd0, 7'h00, 64'd0);
      else run_word(w, w[6:0], 3'd0, 7'h00, 64'd0);
    end
    end_test("flags");

    $display("%0d tests, %0d transactions, %0d errors", tests, n_trans, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
rtl/exu_pkg.sv
rtl/exu_decode.sv
rtl/exu_execute.sv
rtl/exu_result.sv
rtl/exu_top.sv
tests/exu_tb.sv

/* Makefile */
# Verilator build for the execute stage testbench
VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
